//--- compile.f
hw/mult_pkg.sv
hw/mult_controller.sv
hw/sequential_multiplier.sv
hw/mult_axil_regs.sv
hw/mult_periph_top.sv
testbench/tb_mult_periph.sv

//--- testbench/tb_mult_periph.sv
module tb_mult_periph;

    localparam int PERIOD       = 100;
    localparam int RESET_CYCLES = 10;
    localparam int MULT_RUNS    = 50;
    localparam int POLL_MAX     = 20;
    localparam int BUS_CYCLES   = 5;
    // A run is three writes, one product read and the STATUS polls.
    localparam int RUN_CYCLES   = (POLL_MAX + 6) * BUS_CYCLES;
    localparam int TIMEOUT      = (RESET_CYCLES + (MULT_RUNS + 5) * RUN_CYCLES) * PERIOD;

    logic                CLK;
    logic                RST;
    mult_pkg::axil_req_t req;
    mult_pkg::axil_rsp_t rsp;
    integer              seed;

    mult_periph_top u_dut (
        .CLK     (CLK),
        .RST     (RST),
        .bus_req (req),
        .bus_rsp (rsp)
    );

    initial
    begin
        CLK = 1'b0;
        forever #(PERIOD / 2) CLK = ~CLK;
    end

    initial
    begin
        #(TIMEOUT);
        $display("Timeout: the tests did not finish, the bus or the multiplier hung");
        $display("Errors found");
        $fatal(1);
    end

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else
        begin
            $display("CHECK FAILED time=%0t %s expected=%h actual=%h",
                     $time, name, expected, actual);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    // With hold > 0 bready stays low and a competing write is presented meanwhile.
    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                             input logic [1:0] exp_resp, input int hold);
        @(posedge CLK);
        req.awvalid <= 1'b1;
        req.awaddr  <= addr;
        req.wvalid  <= 1'b1;
        req.wdata   <= data;
        @(negedge CLK);
        while (!rsp.awready) @(negedge CLK);
        check_equal("wready", 1'b1, rsp.wready);
        @(posedge CLK);
        if (hold == 0)
        begin
            req.awvalid <= 1'b0;
            req.wvalid  <= 1'b0;
            req.bready  <= 1'b1;
        end
        else
        begin
            req.wdata <= ~data;
        end
        @(negedge CLK);
        while (!rsp.bvalid) @(negedge CLK);
        for (int i = 0; i < hold; i++)
        begin
            @(negedge CLK);
            check_equal("bvalid", 1'b1, rsp.bvalid);
            check_equal("awready", 1'b0, rsp.awready);
            check_equal("wready", 1'b0, rsp.wready);
            check_equal("bresp", exp_resp, rsp.bresp);
        end
        if (hold > 0)
        begin
            @(posedge CLK);
            req.awvalid <= 1'b0;
            req.wvalid  <= 1'b0;
            req.bready  <= 1'b1;
            @(negedge CLK);
            check_equal("bvalid", 1'b1, rsp.bvalid);
        end
        check_equal("bresp", exp_resp, rsp.bresp);
        @(posedge CLK);
        req.bready <= 1'b0;
    endtask

    // With hold > 0 rready stays low and a read of another offset is presented.
    task automatic read_reg(input logic [7:0] addr, input logic [1:0] exp_resp,
                            input int hold, output logic [31:0] data);
        @(posedge CLK);
        req.arvalid <= 1'b1;
        req.araddr  <= addr;
        @(negedge CLK);
        while (!rsp.arready) @(negedge CLK);
        @(posedge CLK);
        if (hold == 0)
        begin
            req.arvalid <= 1'b0;
            req.rready  <= 1'b1;
        end
        else
        begin
            req.araddr <= addr ^ 8'h10;
        end
        @(negedge CLK);
        while (!rsp.rvalid) @(negedge CLK);
        data = rsp.rdata;
        for (int i = 0; i < hold; i++)
        begin
            @(negedge CLK);
            check_equal("rvalid", 1'b1, rsp.rvalid);
            check_equal("arready", 1'b0, rsp.arready);
            check_equal("rdata", data, rsp.rdata);
        end
        if (hold > 0)
        begin
            @(posedge CLK);
            req.arvalid <= 1'b0;
            req.rready  <= 1'b1;
            @(negedge CLK);
            check_equal("rvalid", 1'b1, rsp.rvalid);
            check_equal("rdata", data, rsp.rdata);
        end
        check_equal("rresp", exp_resp, rsp.rresp);
        @(posedge CLK);
        req.rready <= 1'b0;
    endtask

    task automatic wait_done();
        logic [31:0] status;
        int          polls;
        polls = 0;
        read_reg(mult_pkg::ADDR_STATUS, mult_pkg::RESP_OKAY, 0, status);
        while (!status[mult_pkg::STATUS_DONE_BIT])
        begin
            polls++;
            assert (polls < POLL_MAX)
            else
            begin
                $display("Multiply did not finish: STATUS never showed done");
                $display("Errors found");
                $fatal(1);
            end
            read_reg(mult_pkg::ADDR_STATUS, mult_pkg::RESP_OKAY, 0, status);
        end
        check_equal("STATUS", 32'h2, status);
    endtask

    task automatic run_multiply(input logic signed [15:0] a, input logic signed [15:0] b);
        logic [31:0]        data;
        logic signed [31:0] expected;
        expected = a * b;
        write_reg(mult_pkg::ADDR_OP_A, {{16{a[15]}}, a}, mult_pkg::RESP_OKAY, 0);
        write_reg(mult_pkg::ADDR_OP_B, {{16{b[15]}}, b}, mult_pkg::RESP_OKAY, 0);
        write_reg(mult_pkg::ADDR_CTRL, 32'h1, mult_pkg::RESP_OKAY, 0);
        wait_done();
        read_reg(mult_pkg::ADDR_PRODUCT, mult_pkg::RESP_OKAY, 0, data);
        check_equal("PRODUCT", expected, data);
    endtask

    task automatic after_reset_values();
        logic [31:0] data;
        for (int i = 0; i < 5; i++)
        begin
            read_reg(8'(i * 4), mult_pkg::RESP_OKAY, 0, data);
            check_equal($sformatf("register 0x%02h", i * 4), 32'h0, data);
        end
    endtask

    task automatic corner_products();
        run_multiply(16'sd0, -16'sd5);
        run_multiply(16'sd1, -16'sd1);
        run_multiply(-16'sd32768, -16'sd32768);
        run_multiply(16'sd32767, -16'sd32768);
        run_multiply(-16'sd1, -16'sd1);
        run_multiply(16'sd12345, -16'sd321);
    endtask

    task automatic random_products();
        integer va;
        integer vb;
        for (int i = 0; i < 40; i++)
        begin
            va = $random(seed);
            vb = $random(seed);
            run_multiply(va[15:0], vb[15:0]);
        end
    endtask

    task automatic start_gating();
        logic [31:0] data;
        write_reg(mult_pkg::ADDR_OP_A, 32'd100, mult_pkg::RESP_OKAY, 0);
        write_reg(mult_pkg::ADDR_OP_B, -32'sd7, mult_pkg::RESP_OKAY, 0);
        write_reg(mult_pkg::ADDR_CTRL, 32'h1, mult_pkg::RESP_OKAY, 0);
        read_reg(mult_pkg::ADDR_STATUS, mult_pkg::RESP_OKAY, 0, data);
        check_equal("STATUS", 32'h1, data);
        // New operand and a second start, both while the first multiply runs.
        write_reg(mult_pkg::ADDR_OP_A, -32'sd300, mult_pkg::RESP_OKAY, 0);
        write_reg(mult_pkg::ADDR_CTRL, 32'h1, mult_pkg::RESP_OKAY, 0);
        wait_done();
        read_reg(mult_pkg::ADDR_PRODUCT, mult_pkg::RESP_OKAY, 0, data);
        check_equal("PRODUCT", -32'sd700, data);
        read_reg(mult_pkg::ADDR_OP_A, mult_pkg::RESP_OKAY, 0, data);
        check_equal("OP_A", 32'hFFFF_FED4, data);
        write_reg(mult_pkg::ADDR_OP_B, 32'd21, mult_pkg::RESP_OKAY, 0);
        write_reg(mult_pkg::ADDR_CTRL, 32'h1, mult_pkg::RESP_OKAY, 0);
        wait_done();
        read_reg(mult_pkg::ADDR_PRODUCT, mult_pkg::RESP_OKAY, 0, data);
        check_equal("PRODUCT", -32'sd6300, data);
    endtask

    task automatic bad_accesses();
        logic [31:0] data;
        run_multiply(-16'sd300, 16'sd21);
        read_reg(8'h14, mult_pkg::RESP_SLVERR, 0, data);
        write_reg(mult_pkg::ADDR_STATUS, 32'h3, mult_pkg::RESP_SLVERR, 0);
        write_reg(mult_pkg::ADDR_PRODUCT, 32'h1234_5678, mult_pkg::RESP_SLVERR, 0);
        write_reg(8'h20, 32'h1, mult_pkg::RESP_SLVERR, 0);
        read_reg(mult_pkg::ADDR_OP_A, mult_pkg::RESP_OKAY, 0, data);
        check_equal("OP_A", -32'sd300, data);
        read_reg(mult_pkg::ADDR_OP_B, mult_pkg::RESP_OKAY, 0, data);
        check_equal("OP_B", 32'd21, data);
        read_reg(mult_pkg::ADDR_STATUS, mult_pkg::RESP_OKAY, 0, data);
        check_equal("STATUS", 32'h2, data);
        read_reg(mult_pkg::ADDR_PRODUCT, mult_pkg::RESP_OKAY, 0, data);
        check_equal("PRODUCT", -32'sd6300, data);
    endtask

    task automatic back_pressure();
        logic [31:0] data;
        write_reg(mult_pkg::ADDR_OP_A, 32'h1234, mult_pkg::RESP_OKAY, 5);
        read_reg(mult_pkg::ADDR_OP_A, mult_pkg::RESP_OKAY, 5, data);
        check_equal("OP_A", 32'h1234, data);
        write_reg(8'h20, 32'h0, mult_pkg::RESP_SLVERR, 4);
        read_reg(8'h14, mult_pkg::RESP_SLVERR, 4, data);
        read_reg(mult_pkg::ADDR_OP_A, mult_pkg::RESP_OKAY, 0, data);
        check_equal("OP_A", 32'h1234, data);
    endtask

    initial
    begin
        seed = 40663;
        req  = '0;
        RST  = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        RST <= 1'b1;
        after_reset_values();
        corner_products();
        random_products();
        start_gating();
        bad_accesses();
        back_pressure();
        $display("No errors");
        $finish;
    end

endmodule

//--- hw/mult_periph_top.sv
module mult_periph_top (
    input  logic                CLK,
    input  logic                RST,
    input  mult_pkg::axil_req_t bus_req,
    output mult_pkg::axil_rsp_t bus_rsp
);

    logic                           start;
    logic                           ready;
    logic [mult_pkg::OPERAND_W-1:0] op_a;
    logic [mult_pkg::OPERAND_W-1:0] op_b;
    logic [mult_pkg::PRODUCT_W-1:0] product;

    mult_axil_regs u_regs (
        .CLK     (CLK),
        .RST     (RST),
        .bus_req (bus_req),
        .ready   (ready),
        .product (product),
        .bus_rsp (bus_rsp),
        .start   (start),
        .op_a    (op_a),
        .op_b    (op_b)
    );

    sequential_multiplier u_core (
        .CLK     (CLK),
        .RST     (RST),
        .start   (start),
        .a       (op_a),
        .b       (op_b),
        .ready   (ready),
        .product (product)
    );

endmodule

//--- hw/mult_axil_regs.sv
module mult_axil_regs (
    input  logic                           CLK,
    input  logic                           RST,
    input  mult_pkg::axil_req_t            bus_req,
    input  logic                           ready,
    input  logic [mult_pkg::PRODUCT_W-1:0] product,
    output mult_pkg::axil_rsp_t            bus_rsp,
    output logic                           start,
    output logic [mult_pkg::OPERAND_W-1:0] op_a,
    output logic [mult_pkg::OPERAND_W-1:0] op_b
);

    localparam int EXT_W = mult_pkg::AXIL_DATA_W - mult_pkg::OPERAND_W;

    logic                             awready_q;
    logic                             bvalid_q;
    logic [mult_pkg::RESP_W-1:0]      bresp_q;
    logic                             arready_q;
    logic                             rvalid_q;
    logic [mult_pkg::AXIL_DATA_W-1:0] rdata_q;
    logic [mult_pkg::RESP_W-1:0]      rresp_q;

    logic [mult_pkg::OPERAND_W-1:0]   op_a_q;
    logic [mult_pkg::OPERAND_W-1:0]   op_b_q;
    logic [mult_pkg::PRODUCT_W-1:0]   product_q;
    logic                             start_q;
    logic                             busy_q;
    logic                             done_q;

    logic                             wr_hs;
    logic                             wr_ok;
    logic                             rd_hs;
    logic                             rd_ok;
    logic                             ctrl_start;
    logic [mult_pkg::AXIL_DATA_W-1:0] rd_data;

    assign wr_hs = awready_q && bus_req.awvalid && bus_req.wvalid;
    assign rd_hs = arready_q && bus_req.arvalid;

    // Only the operands and CTRL are writable.
    assign wr_ok = (bus_req.awaddr == mult_pkg::ADDR_OP_A) ||
                   (bus_req.awaddr == mult_pkg::ADDR_OP_B) ||
                   (bus_req.awaddr == mult_pkg::ADDR_CTRL);

    assign ctrl_start = wr_hs && (bus_req.awaddr == mult_pkg::ADDR_CTRL) &&
                        bus_req.wdata[mult_pkg::CTRL_START_BIT];

    always_ff @(posedge CLK or negedge RST)
    begin
        if (!RST)
        begin
            awready_q <= 1'b0;
            bvalid_q  <= 1'b0;
            bresp_q   <= mult_pkg::RESP_OKAY;
        end
        else
        begin
            awready_q <= bus_req.awvalid && bus_req.wvalid && !awready_q && !bvalid_q;
            if (wr_hs)
            begin
                bvalid_q <= 1'b1;
                bresp_q  <= wr_ok ? mult_pkg::RESP_OKAY : mult_pkg::RESP_SLVERR;
            end
            else if (bvalid_q && bus_req.bready)
            begin
                bvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK or negedge RST)
    begin
        if (!RST)
        begin
            op_a_q <= '0;
            op_b_q <= '0;
        end
        else if (wr_hs)
        begin
            if (bus_req.awaddr == mult_pkg::ADDR_OP_A)
            begin
                op_a_q <= bus_req.wdata[mult_pkg::OPERAND_W-1:0];
            end
            if (bus_req.awaddr == mult_pkg::ADDR_OP_B)
            begin
                op_b_q <= bus_req.wdata[mult_pkg::OPERAND_W-1:0];
            end
        end
    end

    // A start while busy is dropped.
    always_ff @(posedge CLK or negedge RST)
    begin
        if (!RST)
        begin
            start_q   <= 1'b0;
            busy_q    <= 1'b0;
            done_q    <= 1'b0;
            product_q <= '0;
        end
        else
        begin
            start_q <= ctrl_start && !busy_q;
            if (ctrl_start && !busy_q)
            begin
                busy_q <= 1'b1;
                done_q <= 1'b0;
            end
            else if (ready)
            begin
                busy_q    <= 1'b0;
                done_q    <= 1'b1;
                product_q <= product;
            end
        end
    end

    always_comb
    begin
        rd_ok   = 1'b1;
        rd_data = '0;
        case (bus_req.araddr)
            mult_pkg::ADDR_OP_A:    rd_data = {{EXT_W{op_a_q[mult_pkg::OPERAND_W-1]}}, op_a_q};
            mult_pkg::ADDR_OP_B:    rd_data = {{EXT_W{op_b_q[mult_pkg::OPERAND_W-1]}}, op_b_q};
            mult_pkg::ADDR_CTRL:    rd_data = '0;
            mult_pkg::ADDR_STATUS:
            begin
                rd_data[mult_pkg::STATUS_BUSY_BIT] = busy_q;
                rd_data[mult_pkg::STATUS_DONE_BIT] = done_q;
            end
            mult_pkg::ADDR_PRODUCT: rd_data = product_q;
            default:                rd_ok   = 1'b0;
        endcase
    end

    always_ff @(posedge CLK or negedge RST)
    begin
        if (!RST)
        begin
            arready_q <= 1'b0;
            rvalid_q  <= 1'b0;
            rdata_q   <= '0;
            rresp_q   <= mult_pkg::RESP_OKAY;
        end
        else
        begin
            arready_q <= bus_req.arvalid && !arready_q && !rvalid_q;
            if (rd_hs)
            begin
                rvalid_q <= 1'b1;
                rdata_q  <= rd_data;
                rresp_q  <= rd_ok ? mult_pkg::RESP_OKAY : mult_pkg::RESP_SLVERR;
            end
            else if (rvalid_q && bus_req.rready)
            begin
                rvalid_q <= 1'b0;
            end
        end
    end

    always_comb
    begin
        bus_rsp.awready = awready_q;
        bus_rsp.wready  = awready_q;
        bus_rsp.bvalid  = bvalid_q;
        bus_rsp.bresp   = bresp_q;
        bus_rsp.arready = arready_q;
        bus_rsp.rvalid  = rvalid_q;
        bus_rsp.rdata   = rdata_q;
        bus_rsp.rresp   = rresp_q;
    end

    assign start = start_q;
    assign op_a  = op_a_q;
    assign op_b  = op_b_q;

    a_b_hold: assert property (@(posedge CLK) disable iff (!RST)
        (bvalid_q && !bus_req.bready) |=> (bvalid_q && $stable(bresp_q)));

    a_r_hold: assert property (@(posedge CLK) disable iff (!RST)
        (rvalid_q && !bus_req.rready) |=> (rvalid_q && $stable(rdata_q) && $stable(rresp_q)));

endmodule

//--- hw/sequential_multiplier.sv
module sequential_multiplier (
    input  logic                           CLK,
    input  logic                           RST,
    input  logic                           start,
    input  logic [mult_pkg::OPERAND_W-1:0] a,
    input  logic [mult_pkg::OPERAND_W-1:0] b,
    output logic                           ready,
    output logic [mult_pkg::PRODUCT_W-1:0] product
);

    localparam int EXT_W = mult_pkg::PRODUCT_W - mult_pkg::OPERAND_W;

    logic load;
    logic iterate;
    logic clear;
    logic negate;
    logic last_iter;

    logic [mult_pkg::OPERAND_W-1:0] mcand_q;
    logic [mult_pkg::OPERAND_W-1:0] mplier_q;
    logic [mult_pkg::CNT_W-1:0]     count_q;
    logic [mult_pkg::PRODUCT_W-1:0] acc_q;
    logic [mult_pkg::PRODUCT_W-1:0] pp_sel;
    logic [mult_pkg::PRODUCT_W-1:0] pp_signed;
    logic [mult_pkg::PRODUCT_W-1:0] pp_shifted;

    mult_controller u_ctrl (
        .CLK       (CLK),
        .RST       (RST),
        .start     (start),
        .last_iter (last_iter),
        .load      (load),
        .iterate   (iterate),
        .clear     (clear),
        .negate    (negate),
        .ready     (ready)
    );

    assign last_iter = (count_q == mult_pkg::CNT_W'(mult_pkg::ITER_COUNT - 1));

    // Multiplicand is held, multiplier shifts right one bit per iteration.
    always_ff @(posedge CLK)
    begin
        if (load)
        begin
            mcand_q  <= a;
            mplier_q <= b;
        end
        else if (iterate)
        begin
            mplier_q <= mplier_q >> 1;
        end
    end

    always_ff @(posedge CLK or negedge RST)
    begin
        if (!RST)
        begin
            count_q <= '0;
        end
        else if (clear)
        begin
            count_q <= '0;
        end
        else if (iterate)
        begin
            // Wraps to zero after the last iteration.
            count_q <= count_q + 1'b1;
        end
    end

    always_comb
    begin
        pp_sel     = mplier_q[0] ? {{EXT_W{mcand_q[mult_pkg::OPERAND_W-1]}}, mcand_q} : '0;
        pp_signed  = negate ? -pp_sel : pp_sel;
        pp_shifted = pp_signed << count_q;
    end

    always_ff @(posedge CLK)
    begin
        if (clear)
        begin
            acc_q <= '0;
        end
        else if (iterate)
        begin
            acc_q <= acc_q + pp_shifted;
        end
    end

    assign product = ready ? acc_q : '0;

    a_count_idle: assert property (@(posedge CLK) disable iff (!RST)
        !iterate |=> $stable(count_q));

endmodule

//--- hw/mult_controller.sv
module mult_controller (
    input  logic CLK,
    input  logic RST,
    input  logic start,
    input  logic last_iter,
    output logic load,
    output logic iterate,
    output logic clear,
    output logic negate,
    output logic ready
);

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_RUN  = 2'd1,
        ST_DONE = 2'd2
    } state_t;

    state_t state_q;
    state_t state_d;

    always_ff @(posedge CLK or negedge RST)
    begin
        if (!RST)
        begin
            state_q <= ST_IDLE;
        end
        else
        begin
            state_q <= state_d;
        end
    end

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:
            begin
                if (start)
                begin
                    state_d = ST_RUN;
                end
            end
            ST_RUN:
            begin
                // Bit 15 is the last one to be added.
                if (last_iter)
                begin
                    state_d = ST_DONE;
                end
            end
            ST_DONE:
            begin
                state_d = ST_IDLE;
            end
            default:
            begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_comb
    begin
        load    = 1'b0;
        clear   = 1'b0;
        iterate = 1'b0;
        negate  = 1'b0;
        ready   = 1'b0;
        case (state_q)
            ST_IDLE:
            begin
                load  = start;
                clear = start;
            end
            ST_RUN:
            begin
                iterate = 1'b1;
                // Sign bit of the multiplier has negative weight.
                negate  = last_iter;
            end
            ST_DONE:
            begin
                ready = 1'b1;
            end
            default:
            begin
                ready = 1'b0;
            end
        endcase
    end

    // Ready follows a load after all iterations and lasts one cycle.
    a_ready_one_cycle: assert property (@(posedge CLK) disable iff (!RST)
        load |=> (!ready) [*mult_pkg::ITER_COUNT] ##1 ready ##1 !ready);

    // The register block never starts a running core.
    a_start_only_idle: assert property (@(posedge CLK) disable iff (!RST)
        start |-> (state_q == ST_IDLE));

endmodule

//--- hw/mult_pkg.sv
package mult_pkg;

    // Multiplier widths.
    localparam int OPERAND_W  = 16;
    localparam int PRODUCT_W  = 32;
    localparam int ITER_COUNT = 16;
    localparam int CNT_W      = $clog2(ITER_COUNT);

    // Bus widths.
    localparam int AXIL_ADDR_W = 8;
    localparam int AXIL_DATA_W = 32;
    localparam int RESP_W      = 2;

    // Register map.
    localparam logic [AXIL_ADDR_W-1:0] ADDR_OP_A    = 8'h00;
    localparam logic [AXIL_ADDR_W-1:0] ADDR_OP_B    = 8'h04;
    localparam logic [AXIL_ADDR_W-1:0] ADDR_CTRL    = 8'h08;
    localparam logic [AXIL_ADDR_W-1:0] ADDR_STATUS  = 8'h0C;
    localparam logic [AXIL_ADDR_W-1:0] ADDR_PRODUCT = 8'h10;

    // Bit positions inside CTRL and STATUS.
    localparam int CTRL_START_BIT  = 0;
    localparam int STATUS_BUSY_BIT = 0;
    localparam int STATUS_DONE_BIT = 1;

    // Response codes.
    localparam logic [RESP_W-1:0] RESP_OKAY   = 2'b00;
    localparam logic [RESP_W-1:0] RESP_SLVERR = 2'b10;

    // Master to slave.
    typedef struct packed {
        logic                   awvalid;
        logic [AXIL_ADDR_W-1:0] awaddr;
        logic                   wvalid;
        logic [AXIL_DATA_W-1:0] wdata;
        logic                   bready;
        logic                   arvalid;
        logic [AXIL_ADDR_W-1:0] araddr;
        logic                   rready;
    } axil_req_t;

    // Slave to master.
    typedef struct packed {
        logic                   awready;
        logic                   wready;
        logic                   bvalid;
        logic [RESP_W-1:0]      bresp;
        logic                   arready;
        logic                   rvalid;
        logic [AXIL_DATA_W-1:0] rdata;
        logic [RESP_W-1:0]      rresp;
    } axil_rsp_t;

endpackage
